// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - design/rename_pkg.sv
  - design/alloc_if.sv
  - design/init_counter.sv
  - design/rename_ctrl.sv
  - design/free_list.sv
  - design/rat_table.sv
  - design/rename_top.sv
  - target: simulation
    files:
      - testbench/rename_tb.sv

// ==== design/alloc_if.sv ====
// tag allocation path between the alias table and the free list
interface alloc_if import rename_pkg::*; ();

  logic [TAG_W:0]            free_count;  // tags held in the queue
  logic [2:0][TAG_W-1:0]     head_tags;   // [0] is the oldest
  logic                      pop;
  logic [1:0]                pop_num;     // 1 to 3 when pop is high

  // queue side
  modport pool (
    output free_count,
    output head_tags,
    input  pop,
    input  pop_num
  );

  // consumer side, the rename table
  modport user (
    input  free_count,
    input  head_tags,
    output pop,
    output pop_num
  );

endinterface

// ==== design/free_list.sv ====
module free_list import rename_pkg::*; (
  input  logic             clk,
  input  logic             rst_N_in,
  input  logic             init_push,
  input  logic [TAG_W-1:0] init_tag,
  input  logic             free_valid,
  input  logic [TAG_W-1:0] free_tag,
  alloc_if.pool            alloc
);

  logic [NUM_PHYS_REGS-1:0][TAG_W-1:0] mem;
  logic [TAG_W-1:0]                    head;
  logic [TAG_W-1:0]                    tail;
  logic [TAG_W:0]                      count;
  logic                                push;
  logic [TAG_W-1:0]                    push_tag;
  logic [1:0]                          pop_n;

  // init walk and commit share the single write port
  assign push     = init_push || free_valid;
  assign push_tag = init_push ? init_tag : free_tag;
  assign pop_n    = alloc.pop ? alloc.pop_num : 2'd0;

  // tag storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail] <= push_tag;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      head  <= head + TAG_W'(pop_n);
      count <= count + (TAG_W + 1)'(push) - (TAG_W + 1)'(pop_n);
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      alloc.head_tags[i] = mem[head + TAG_W'(i)];
    end
  end

  assign alloc.free_count = count;

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_N_in)
    push |-> count < NUM_PHYS_REGS
  );

  a_no_overpop: assert property (
    @(posedge clk) disable iff (!rst_N_in)
    alloc.pop |-> (TAG_W + 1)'(alloc.pop_num) <= count
  );

  // commit cannot hand back tags before the walk has filled the queue
  a_no_return_in_init: assert property (
    @(posedge clk) disable iff (!rst_N_in)
    init_push |-> !free_valid
  );

endmodule

// ==== design/init_counter.sv ====
module init_counter import rename_pkg::*; (
  input  logic             clk,
  input  logic             rst_N_in,
  input  logic             start,
  output logic [TAG_W-1:0] count,
  output logic             done
);

  logic running;

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      running <= 1'b0;
      count   <= '0;
    end else if (start) begin
      running <= 1'b1;
      count   <= '0;
    end else if (running) begin
      if (done) begin
        running <= 1'b0;  // walk finished, hold last value
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign done = running && (count == TAG_W'(NUM_INIT_FREE - 1));

  // a new walk may only begin once the previous one is over
  a_no_restart: assert property (
    @(posedge clk) disable iff (!rst_N_in)
    start |-> !running
  );

endmodule

// ==== design/rat_table.sv ====
module rat_table import rename_pkg::*; (
  input  logic       clk,
  input  logic       rst_N_in,
  input  uop_insn    in_uop,
  input  logic       accept,
  alloc_if.user      alloc,
  output logic [1:0] alloc_need,
  output rob_entry   rob_data,
  output logic       rob_valid,
  output regfile_wr  regfile
);

  // one slot per arch register plus nzcv on top
  logic [NUM_ARCH_REGS:0][TAG_W-1:0] map_q;

  logic [ARCH_W-1:0] dst;
  logic [ARCH_W-1:0] src1;
  logic [ARCH_W-1:0] src2;
  logic              set_nzcv;
  logic              is_imm;
  logic [IMM_W-1:0]  imm;

  logic [TAG_W-1:0]  dest_tag;
  logic [TAG_W-1:0]  imm_tag;
  logic [TAG_W-1:0]  nzcv_tag;
  logic [TAG_W-1:0]  r1_tag;
  logic [TAG_W-1:0]  r2_tag;
  logic              is_branch;
  logic [PC_W-1:0]   next_pc;
  rob_entry          entry;

  logic              wr_en_q;
  logic [TAG_W-1:0]  wr_idx_q;
  logic [DATA_W-1:0] wr_data_q;

  // operand word read as rr or ri depending on valb_sel
  always_comb begin
    set_nzcv = in_uop.operands.rr.set_nzcv;  // bit 0 in both forms
    if (in_uop.valb_sel) begin
      dst      = in_uop.operands.rr.dest;
      src1     = in_uop.operands.rr.src1;
      src2     = in_uop.operands.rr.src2;
      imm      = '0;
    end else begin
      dst      = in_uop.operands.ri.dest;
      src1     = in_uop.operands.ri.src;
      src2     = '0;  // replaced by the immediate tag
      imm      = in_uop.operands.ri.imm;
    end
  end

  assign is_imm = !in_uop.valb_sel;

  // head order is dest, then imm, then nzcv
  assign dest_tag = alloc.head_tags[0];
  assign imm_tag  = alloc.head_tags[1];
  assign nzcv_tag = is_imm ? alloc.head_tags[2] : alloc.head_tags[1];

  assign r1_tag = map_q[src1];
  assign r2_tag = is_imm ? imm_tag : map_q[src2];

  assign alloc_need    = 2'd1 + 2'(is_imm) + 2'(set_nzcv);
  assign alloc.pop     = accept;
  assign alloc.pop_num = alloc_need;

  assign is_branch = (in_uop.uopcode == UOP_BL) || (in_uop.uopcode == UOP_BCOND);
  assign next_pc   = (is_branch && in_uop.predict_taken) ? in_uop.branch_target
                                                         : in_uop.pc + PC_W'(4);

  always_comb begin
    entry.pc        = in_uop.pc;
    entry.next_pc   = next_pc;
    entry.uop       = in_uop;
    entry.r1_phys   = r1_tag;
    entry.r2_phys   = r2_tag;
    entry.dest_phys = dest_tag;
    entry.nzcv_phys = set_nzcv ? nzcv_tag : map_q[NUM_ARCH_REGS];  // keep old flags
    entry.status    = ISSUED;
  end

  // alias table starts as the identity map
  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int i = 0; i <= NUM_ARCH_REGS; i++) begin
        map_q[i] <= TAG_W'(i);
      end
    end else if (accept) begin
      map_q[dst] <= dest_tag;
      if (set_nzcv) begin
        map_q[NUM_ARCH_REGS] <= nzcv_tag;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rob_valid <= 1'b0;
      wr_en_q   <= 1'b0;
    end else begin
      rob_valid <= accept;
      wr_en_q   <= accept && is_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rob_data  <= entry;
      wr_idx_q  <= imm_tag;
      wr_data_q <= DATA_W'(imm);  // zero extended
    end
  end

  assign regfile.en    = wr_en_q;
  assign regfile.index = wr_idx_q;
  assign regfile.data  = wr_data_q;

endmodule

// ==== design/rename_ctrl.sv ====
module rename_ctrl import rename_pkg::*; (
  input  logic           clk,
  input  logic           rst_N_in,
  input  logic           init_done,
  input  logic [1:0]     alloc_need,
  input  logic [TAG_W:0] free_count,
  input  logic           in_valid,
  input  logic           rob_ready,
  output logic           init_start,
  output logic           init_push,
  output logic           in_ready,
  output logic           accept
);

  logic [1:0] state;
  logic       walk_started;
  logic       can_go;

  // enough room downstream and enough tags for this uop
  assign can_go = rob_ready && (free_count >= (TAG_W + 1)'(alloc_need));

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      state        <= CTRL_INIT;
      walk_started <= 1'b0;
    end else begin
      if (init_start) begin
        walk_started <= 1'b1;
      end
      case (state)
        CTRL_INIT: begin
          if (init_done) begin
            state <= CTRL_RUN;
          end
        end
        CTRL_RUN: begin
          if (in_valid && !can_go) begin
            state <= CTRL_STALL;
          end
        end
        CTRL_STALL: begin
          if (can_go) begin
            state <= CTRL_RUN;
          end
        end
        default: state <= CTRL_INIT;
      endcase
    end
  end

  assign init_start = (state == CTRL_INIT) && !walk_started;  // one cycle kick
  assign init_push  = (state == CTRL_INIT) && walk_started;   // one tag per cycle
  assign in_ready   = (state == CTRL_RUN) && can_go;
  assign accept     = in_valid && in_ready;

  // accepts happen only in run
  a_accept_in_run: assert property (
    @(posedge clk) disable iff (!rst_N_in)
    accept |-> (state == CTRL_RUN)
  );

endmodule

// ==== design/rename_pkg.sv ====
package rename_pkg;

  // machine sizes
  localparam int NUM_ARCH_REGS = 32;  // nzcv sits one slot above these
  localparam int NUM_PHYS_REGS = 64;
  localparam int TAG_W         = 6;
  localparam int ARCH_W        = 5;
  localparam int NUM_INIT_FREE = 31;  // tags 33..63 after the walk
  localparam int INIT_BASE     = NUM_ARCH_REGS + 1;  // first tag not taken by identity map
  localparam int IMM_W         = 12;
  localparam int PC_W          = 64;
  localparam int DATA_W        = 64;
  localparam int OPND_W        = 28;  // common width of both operand forms

  // rename controller states
  localparam logic [1:0] CTRL_INIT  = 2'd0;
  localparam logic [1:0] CTRL_RUN   = 2'd1;
  localparam logic [1:0] CTRL_STALL = 2'd2;

  typedef enum logic [2:0] {
    UOP_ALU,
    UOP_LOAD,
    UOP_STORE,
    UOP_BL,
    UOP_BCOND
  } uop_code;

  // register-register form
  typedef struct packed {
    logic [OPND_W-3*ARCH_W-2:0] pad;
    logic [ARCH_W-1:0]          dest;
    logic [ARCH_W-1:0]          src1;
    logic [ARCH_W-1:0]          src2;
    logic                       set_nzcv;
  } uop_rr;

  // register-immediate form
  typedef struct packed {
    logic [OPND_W-2*ARCH_W-IMM_W-2:0] pad;
    logic [ARCH_W-1:0]                dest;
    logic [ARCH_W-1:0]                src;
    logic [IMM_W-1:0]                 imm;
    logic                             set_nzcv;
  } uop_ri;

  typedef union packed {
    uop_rr rr;
    uop_ri ri;
  } uop_operands;

  typedef struct packed {
    logic [PC_W-1:0] pc;
    uop_code         uopcode;
    logic            valb_sel;       // 1 selects the rr form
    logic            predict_taken;
    logic [PC_W-1:0] branch_target;
    uop_operands     operands;
  } uop_insn;

  typedef enum logic [1:0] {
    ISSUED,
    DONE,
    EXCEPTION
  } rob_status;

  typedef struct packed {
    logic [PC_W-1:0]  pc;
    logic [PC_W-1:0]  next_pc;
    uop_insn          uop;
    logic [TAG_W-1:0] r1_phys;
    logic [TAG_W-1:0] r2_phys;
    logic [TAG_W-1:0] dest_phys;
    logic [TAG_W-1:0] nzcv_phys;
    rob_status        status;
  } rob_entry;

  typedef struct packed {
    logic              en;
    logic [TAG_W-1:0]  index;
    logic [DATA_W-1:0] data;
  } regfile_wr;

endpackage

// ==== design/rename_top.sv ====
module rename_top import rename_pkg::*; (
  input  logic             clk,
  input  logic             rst_N_in,

  // uop in
  input  logic             in_valid,
  input  uop_insn          in_uop,
  output logic             in_ready,

  // reorder buffer
  output rob_entry         rob_data,
  output logic             rob_valid,
  input  logic             rob_ready,

  // tags back from commit
  input  logic             free_valid,
  input  logic [TAG_W-1:0] free_tag,

  // immediate write to the register file
  output regfile_wr        regfile
);

  logic             init_start;
  logic             init_done;
  logic             init_push;
  logic [TAG_W-1:0] init_count;
  logic [TAG_W-1:0] init_tag;
  logic [1:0]       alloc_need;
  logic             accept;

  alloc_if u_alloc_if ();

  assign init_tag = init_count + TAG_W'(INIT_BASE);  // walk starts above the identity map

  init_counter u_init_counter (
    .clk      (clk),
    .rst_N_in (rst_N_in),
    .start    (init_start),
    .count    (init_count),
    .done     (init_done)
  );

  rename_ctrl u_rename_ctrl (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .init_done  (init_done),
    .alloc_need (alloc_need),
    .free_count (u_alloc_if.free_count),
    .in_valid   (in_valid),
    .rob_ready  (rob_ready),
    .init_start (init_start),
    .init_push  (init_push),
    .in_ready   (in_ready),
    .accept     (accept)
  );

  free_list u_free_list (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .init_push  (init_push),
    .init_tag   (init_tag),
    .free_valid (free_valid),
    .free_tag   (free_tag),
    .alloc      (u_alloc_if.pool)
  );

  rat_table u_rat_table (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .in_uop     (in_uop),
    .accept     (accept),
    .alloc      (u_alloc_if.user),
    .alloc_need (alloc_need),
    .rob_data   (rob_data),
    .rob_valid  (rob_valid),
    .regfile    (regfile)
  );

endmodule

// ==== filelist.f ====
design/rename_pkg.sv
design/alloc_if.sv
design/init_counter.sv
design/rename_ctrl.sv
design/free_list.sv
design/rat_table.sv
design/rename_top.sv
testbench/rename_tb.sv

// ==== testbench/rename_tb.sv ====
module rename_tb import rename_pkg::*; ();

  localparam int RESET_CYCLES = 4;
  localparam int HOLD_CYCLES  = 5;
  localparam int NUM_RAND     = 40;  // the queue runs dry well before this many
  localparam int NUM_DIRECTED = 23;
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_INIT_FREE + 1
                                + 3 * (NUM_DIRECTED + NUM_RAND) + 2 * HOLD_CYCLES + 30;

  logic             clk = 1'b0;
  logic             rst_N_in;
  logic             in_valid;
  uop_insn          in_uop;
  logic             in_ready;
  rob_entry         rob_data;
  logic             rob_valid;
  logic             rob_ready;
  logic             free_valid;
  logic [TAG_W-1:0] free_tag;
  regfile_wr        regfile;

  // reference model state
  logic [TAG_W-1:0] ref_map [NUM_ARCH_REGS+1];
  logic [TAG_W-1:0] ref_free [$];
  logic [TAG_W-1:0] retired [$];  // old mappings that commit would hand back
  rob_entry         exp_rob_q [$];
  regfile_wr        exp_rf_q [$];
  logic [PC_W-1:0]  pc_seq = 64'h1000;
  int errors = 0;
  int checked = 0;
  int cycles = 0;
  int tests = 0;
  int passed = 0;

  always #5 clk = ~clk;

  rename_top u_rename_top (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .in_valid   (in_valid),
    .in_uop     (in_uop),
    .in_ready   (in_ready),
    .rob_data   (rob_data),
    .rob_valid  (rob_valid),
    .rob_ready  (rob_ready),
    .free_valid (free_valid),
    .free_tag   (free_tag),
    .regfile    (regfile)
  );

  task automatic value_mismatch(input string sig, input logic [255:0] got,
                                input logic [255:0] exp);
    $display("Fail %s: got 0x%0h expected 0x%0h", sig, got, exp);
    errors++;
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) value_mismatch(sig, got, exp);
  endtask

  task automatic check_rob(input rob_entry got, input rob_entry exp);
    if (got.pc !== exp.pc) value_mismatch("rob_data.pc", got.pc, exp.pc);
    if (got.next_pc !== exp.next_pc) value_mismatch("rob_data.next_pc", got.next_pc, exp.next_pc);
    if (got.uop !== exp.uop) value_mismatch("rob_data.uop", got.uop, exp.uop);
    if (got.r1_phys !== exp.r1_phys) value_mismatch("rob_data.r1_phys", got.r1_phys, exp.r1_phys);
    if (got.r2_phys !== exp.r2_phys) value_mismatch("rob_data.r2_phys", got.r2_phys, exp.r2_phys);
    if (got.dest_phys !== exp.dest_phys) begin
      value_mismatch("rob_data.dest_phys", got.dest_phys, exp.dest_phys);
    end
    if (got.nzcv_phys !== exp.nzcv_phys) begin
      value_mismatch("rob_data.nzcv_phys", got.nzcv_phys, exp.nzcv_phys);
    end
    if (got.status !== exp.status) value_mismatch("rob_data.status", got.status, exp.status);
  endtask

  task automatic check_regfile(input regfile_wr got, input regfile_wr exp);
    if (got.en !== exp.en) begin
      value_mismatch("regfile.en", got.en, exp.en);
    end else if (exp.en) begin
      if (got.index !== exp.index) value_mismatch("regfile.index", got.index, exp.index);
      if (got.data !== exp.data) value_mismatch("regfile.data", got.data, exp.data);
    end
  endtask

  function automatic int need_of(input uop_insn u);
    if (u.valb_sel) return 1 + int'(u.operands.rr.set_nzcv);
    return 2 + int'(u.operands.ri.set_nzcv);  // dest plus immediate tag
  endfunction

  // expected entry and write for one uop plus the model update
  function automatic void ref_rename(input uop_insn u, output rob_entry e, output regfile_wr w);
    logic [ARCH_W-1:0] d;
    logic [ARCH_W-1:0] s1;
    logic              nz;
    logic [TAG_W-1:0]  it;
    d  = u.valb_sel ? u.operands.rr.dest : u.operands.ri.dest;
    s1 = u.valb_sel ? u.operands.rr.src1 : u.operands.ri.src;
    nz = u.valb_sel ? u.operands.rr.set_nzcv : u.operands.ri.set_nzcv;
    e = '0;
    w = '0;
    e.pc = u.pc;
    e.uop = u;
    e.status = ISSUED;
    e.next_pc = ((u.uopcode == UOP_BL || u.uopcode == UOP_BCOND) && u.predict_taken)
                ? u.branch_target : u.pc + 64'd4;
    e.r1_phys = ref_map[s1];
    e.dest_phys = ref_free.pop_front();
    if (u.valb_sel) begin
      e.r2_phys = ref_map[u.operands.rr.src2];
    end else begin
      it = ref_free.pop_front();
      e.r2_phys = it;
      w.en = 1'b1;
      w.index = it;
      w.data = DATA_W'(u.operands.ri.imm);
    end
    e.nzcv_phys = nz ? ref_free.pop_front() : ref_map[NUM_ARCH_REGS];
    if (nz) begin
      retired.push_back(ref_map[NUM_ARCH_REGS]);
      ref_map[NUM_ARCH_REGS] = e.nzcv_phys;
    end
    retired.push_back(ref_map[d]);
    ref_map[d] = e.dest_phys;
  endfunction

  function automatic uop_insn make_uop(input bit rr, input int d, input int s1, input int s2,
                                       input bit nz);
    uop_insn u;
    u = '0;
    u.pc = pc_seq;
    pc_seq = pc_seq + 64'd4;
    u.uopcode = UOP_ALU;
    u.valb_sel = rr;
    if (rr) begin
      u.operands.rr.dest = ARCH_W'(d);
      u.operands.rr.src1 = ARCH_W'(s1);
      u.operands.rr.src2 = ARCH_W'(s2);
      u.operands.rr.set_nzcv = nz;
    end else begin
      u.operands.ri.dest = ARCH_W'(d);
      u.operands.ri.src = ARCH_W'(s1);
      u.operands.ri.imm = IMM_W'(s2);  // s2 carries the immediate here
      u.operands.ri.set_nzcv = nz;
    end
    return u;
  endfunction

  function automatic uop_insn random_uop();
    uop_insn u;
    u = '0;
    u.pc = {$urandom, $urandom} & ~64'h3;
    u.uopcode = uop_code'($urandom_range(4));
    u.valb_sel = $urandom_range(1);
    u.predict_taken = $urandom_range(1);
    u.branch_target = {$urandom, $urandom};
    u.operands = uop_operands'(OPND_W'($urandom));
    return u;
  endfunction

  // starts and ends on a falling edge with in_valid low
  task automatic issue_uop(input uop_insn u);
    rob_entry  e;
    regfile_wr w;
    in_valid = 1'b1;
    in_uop = u;
    #2;
    while (!in_ready) begin
      @(negedge clk);
      #2;
    end
    ref_rename(u, e, w);
    exp_rob_q.push_back(e);
    exp_rf_q.push_back(w);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic return_tags(input int n);
    repeat (n) begin
      free_valid = 1'b1;
      free_tag = retired.pop_front();
      ref_free.push_back(free_tag);
      @(negedge clk);
    end
    free_valid = 1'b0;
  endtask

  task automatic hold_not_ready();
    repeat (HOLD_CYCLES) begin
      #2;
      check_flag("in_ready", in_ready, 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    while (exp_rob_q.size() > 0) @(negedge clk);
    tests++;
    if (errors == err_before) passed++;
    $display("test %-10s %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  // outputs have settled by the falling edge
  always @(negedge clk) begin
    if (rst_N_in && rob_valid) begin
      if (exp_rob_q.size() == 0) begin
        $display("rob_valid pulsed although no micro-op was accepted");
        errors++;
      end else begin
        check_rob(rob_data, exp_rob_q[0]);
        check_regfile(regfile, exp_rf_q[0]);
        void'(exp_rob_q.pop_front());
        void'(exp_rf_q.pop_front());
        checked++;
      end
    end else if (rst_N_in && regfile.en) begin
      $display("regfile write enabled without a reorder-buffer entry");
      errors++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped accepting micro-ops", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int      e0;
    uop_insn u;
    void'($urandom(32'h35e57064));
    rst_N_in = 1'b0;
    in_valid = 1'b0;
    in_uop = '0;
    rob_ready = 1'b1;
    free_valid = 1'b0;
    free_tag = '0;
    for (int i = 0; i <= NUM_ARCH_REGS; i++) ref_map[i] = TAG_W'(i);
    for (int t = NUM_ARCH_REGS + 1; t < NUM_PHYS_REGS; t++) ref_free.push_back(TAG_W'(t));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_flag("rob_valid", rob_valid, 1'b0);
    check_flag("regfile.en", regfile.en, 1'b0);
    rst_N_in = 1'b1;

    e0 = errors;
    for (int k = 1; k <= NUM_INIT_FREE + 1; k++) begin
      @(negedge clk);
      check_flag("in_ready", in_ready, k == NUM_INIT_FREE + 1);  // high once the walk is over
    end
    finish_test("init_walk", e0);

    e0 = errors;
    issue_uop(make_uop(1, 1, 2, 3, 0));
    issue_uop(make_uop(1, 4, 1, 1, 0));  // reads the new r1
    issue_uop(make_uop(1, 1, 4, 5, 0));
    issue_uop(make_uop(1, 6, 1, 4, 0));
    finish_test("reg_reg", e0);

    e0 = errors;
    issue_uop(make_uop(0, 7, 6, 12'habc, 0));
    issue_uop(make_uop(0, 8, 7, 12'hfff, 0));
    issue_uop(make_uop(1, 9, 8, 7, 0));
    finish_test("reg_imm", e0);

    e0 = errors;
    issue_uop(make_uop(1, 10, 9, 8, 1));
    issue_uop(make_uop(1, 11, 10, 1, 0));
    issue_uop(make_uop(0, 12, 11, 12'h05a, 1));  // all three tags
    issue_uop(make_uop(1, 13, 12, 12, 0));
    finish_test("nzcv", e0);

    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      u = make_uop(1, 14, 13, 2, 0);
      u.uopcode = (k < 2) ? UOP_BCOND : (k < 4) ? UOP_BL : (k == 4) ? UOP_ALU : UOP_LOAD;
      u.predict_taken = (k % 2 == 0) || (k >= 4);
      u.branch_target = {$urandom, $urandom};
      issue_uop(u);
    end
    finish_test("next_pc", e0);

    e0 = errors;
    u = make_uop(1, 15, 14, 1, 0);
    rob_ready = 1'b0;
    in_valid = 1'b1;
    in_uop = u;
    hold_not_ready();
    in_valid = 1'b0;
    rob_ready = 1'b1;
    issue_uop(u);  // same tags as before the stall
    finish_test("rob_stall", e0);

    e0 = errors;
    u = random_uop();
    for (int k = 0; k < NUM_RAND && ref_free.size() >= need_of(u); k++) begin
      issue_uop(u);
      u = random_uop();
    end
    if (ref_free.size() >= need_of(u)) begin
      $display("free list never ran out of tags");
      errors++;
    end
    in_valid = 1'b1;
    in_uop = u;
    hold_not_ready();
    in_valid = 1'b0;
    finish_test("exhaust", e0);

    e0 = errors;
    return_tags(3);
    issue_uop(u);
    while (ref_free.size() > 0) begin
      issue_uop(make_uop(1, 3, 3, 3, 0));  // drains the returned tags in order
    end
    finish_test("tag_return", e0);

    $display("%0d tests, %0d passed, %0d micro-ops checked, %0d errors",
             tests, passed, checked, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
